/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert --timescale 1ns/100ps -j 0
TOP      = commit_tb
FILELIST = commit_top.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run, log to $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* commit_top.f */
logic/csr_pkg.sv
logic/pipe_pkg.sv
logic/wb_stage.sv
logic/csr_file.sv
logic/reg_file.sv
logic/commit_top.sv
sim/commit_checker.sv
sim/commit_tb.sv

/* logic/commit_top.sv */
`timescale 1ns/100ps

module commit_top (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  mem_valid,
    input  pipe_pkg::mem_to_wb_t  mem_bus,
    input  logic [4:0]            rf_raddr,
    output logic                  wb_allowin,
    output pipe_pkg::wb_trace_t   trace,
    output pipe_pkg::redirect_t   redirect,
    output logic [31:0]           rf_rdata
);

    pipe_pkg::csr_cmd_t csr_cmd;
    pipe_pkg::exc_cmd_t exc_cmd;
    logic [31:0]        csr_rvalue;

    wb_stage u_wb_stage (
        .clk        (clk),
        .resetn     (resetn),
        .mem_valid  (mem_valid),
        .mem_bus    (mem_bus),
        .csr_rvalue (csr_rvalue),
        .wb_allowin (wb_allowin),
        .trace      (trace),
        .csr_cmd    (csr_cmd),
        .exc_cmd    (exc_cmd)
    );

    csr_file u_csr_file (
        .clk        (clk),
        .resetn     (resetn),
        .csr_cmd    (csr_cmd),
        .exc_cmd    (exc_cmd),
        .csr_rvalue (csr_rvalue),
        .redirect   (redirect)
    );

    // trace doubles as the write port
    reg_file u_reg_file (
        .clk   (clk),
        .trace (trace),
        .raddr (rf_raddr),
        .rdata (rf_rdata)
    );

endmodule

/* logic/csr_file.sv */
`timescale 1ns/100ps

module csr_file (
    input  logic                clk,
    input  logic                resetn,
    input  pipe_pkg::csr_cmd_t  csr_cmd,
    input  pipe_pkg::exc_cmd_t  exc_cmd,
    output logic [31:0]         csr_rvalue,
    output pipe_pkg::redirect_t redirect
);

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] estat;
    logic [31:0] era;
    logic [31:0] eentry;
    logic [31:0] save0;
    logic [31:0] save1;
    logic [31:0] save2;
    logic [31:0] save3;

    // replace the masked bits that the csr implements
    function automatic logic [31:0] mwrite(
        input logic [31:0] old,
        input logic [31:0] wmask,
        input logic [31:0] wvalue,
        input logic [31:0] impl
    );
        logic [31:0] m;
        m = wmask & impl;
        return (old & ~m) | (wvalue & m);
    endfunction

    // crmd, prmd and estat carry mode state
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd  <= csr_pkg::CRMD_RESET;
            prmd  <= 32'h0;
            estat <= 32'h0;
        end else if (exc_cmd.ex) begin
            prmd[csr_pkg::PLV_IE_W-1:0] <= crmd[csr_pkg::PLV_IE_W-1:0];
            crmd[csr_pkg::PLV_IE_W-1:0] <= '0; // kernel, interrupts off
            estat[21:16]                <= exc_cmd.ecode;
            estat[30:22]                <= exc_cmd.esubcode;
        end else if (exc_cmd.ertn) begin
            crmd[csr_pkg::PLV_IE_W-1:0] <= prmd[csr_pkg::PLV_IE_W-1:0];
        end else if (csr_cmd.we) begin
            case (csr_cmd.num)
                csr_pkg::CSR_CRMD:
                    crmd <= mwrite(crmd, csr_cmd.wmask, csr_cmd.wvalue, csr_pkg::CRMD_WMASK);
                csr_pkg::CSR_PRMD:
                    prmd <= mwrite(prmd, csr_cmd.wmask, csr_cmd.wvalue, csr_pkg::PRMD_WMASK);
                csr_pkg::CSR_ESTAT:
                    estat <= mwrite(estat, csr_cmd.wmask, csr_cmd.wvalue,
                                    csr_pkg::ESTAT_WMASK);
                default: ;
            endcase
        end
    end

    // only era of the plain data csrs is written by hardware
    always_ff @(posedge clk) begin
        if (exc_cmd.ex) begin
            era <= exc_cmd.pc;
        end else if (csr_cmd.we) begin
            case (csr_cmd.num)
                csr_pkg::CSR_ERA:
                    era <= mwrite(era, csr_cmd.wmask, csr_cmd.wvalue, 32'hffff_ffff);
                csr_pkg::CSR_EENTRY:
                    eentry <= mwrite(eentry, csr_cmd.wmask, csr_cmd.wvalue,
                                     csr_pkg::EENTRY_WMASK);
                csr_pkg::CSR_SAVE0:
                    save0 <= mwrite(save0, csr_cmd.wmask, csr_cmd.wvalue, 32'hffff_ffff);
                csr_pkg::CSR_SAVE1:
                    save1 <= mwrite(save1, csr_cmd.wmask, csr_cmd.wvalue, 32'hffff_ffff);
                csr_pkg::CSR_SAVE2:
                    save2 <= mwrite(save2, csr_cmd.wmask, csr_cmd.wvalue, 32'hffff_ffff);
                csr_pkg::CSR_SAVE3:
                    save3 <= mwrite(save3, csr_cmd.wmask, csr_cmd.wvalue, 32'hffff_ffff);
                default: ;
            endcase
        end
    end

    // unknown numbers read zero
    always_comb begin
        case (csr_cmd.num)
            csr_pkg::CSR_CRMD:   csr_rvalue = crmd;
            csr_pkg::CSR_PRMD:   csr_rvalue = prmd;
            csr_pkg::CSR_ESTAT:  csr_rvalue = estat;
            csr_pkg::CSR_ERA:    csr_rvalue = era;
            csr_pkg::CSR_EENTRY: csr_rvalue = eentry;
            csr_pkg::CSR_SAVE0:  csr_rvalue = save0;
            csr_pkg::CSR_SAVE1:  csr_rvalue = save1;
            csr_pkg::CSR_SAVE2:  csr_rvalue = save2;
            csr_pkg::CSR_SAVE3:  csr_rvalue = save3;
            default:             csr_rvalue = 32'h0;
        endcase
    end

    assign redirect.valid = exc_cmd.ex | exc_cmd.ertn;
    assign redirect.pc    = exc_cmd.ex ? eentry : era; // trap entry or return target

    // the stage must hold back csr writes of a flushing instruction
    a_no_write_on_flush: assert property (
        @(posedge clk) disable iff (!resetn)
        !(redirect.valid && csr_cmd.we)
    );

endmodule

/* logic/csr_pkg.sv */
package csr_pkg;

    // exception cause as carried down the pipe
    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_ADEF,
        EXC_ALE,
        EXC_SYS,
        EXC_BRK,
        EXC_INE
    } exc_cause_e;

    // estat ecodes
    localparam logic [5:0] ECODE_ADEF = 6'h08;
    localparam logic [5:0] ECODE_ALE  = 6'h09;
    localparam logic [5:0] ECODE_SYS  = 6'h0b;
    localparam logic [5:0] ECODE_BRK  = 6'h0c;
    localparam logic [5:0] ECODE_INE  = 6'h0d;

    // csr numbers
    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_SAVE0  = 14'h030;
    localparam logic [13:0] CSR_SAVE1  = 14'h031;
    localparam logic [13:0] CSR_SAVE2  = 14'h032;
    localparam logic [13:0] CSR_SAVE3  = 14'h033;

    // da = 1, plv = 0, ie = 0
    localparam logic [31:0] CRMD_RESET = 32'h0000_0008;

    // bits software may change through csrwr / csrxchg
    localparam logic [31:0] CRMD_WMASK   = 32'h0000_01ff;
    localparam logic [31:0] PRMD_WMASK   = 32'h0000_0007;
    localparam logic [31:0] ESTAT_WMASK  = 32'h0000_0003; // sw interrupt bits only
    localparam logic [31:0] EENTRY_WMASK = 32'hffff_ffc0;

    // plv and ie live in the low three bits of crmd and prmd
    localparam int PLV_IE_W = 3;

endpackage

/* logic/pipe_pkg.sv */
package pipe_pkg;

    // bundle handed over by the memory stage
    typedef struct packed {
        logic                  rf_we;
        logic [4:0]            rf_waddr;
        logic [31:0]           rf_wdata;
        logic [31:0]           pc;
        logic                  csr_re;
        logic                  csr_we;
        logic [13:0]           csr_num;
        logic [31:0]           csr_wmask;
        logic [31:0]           csr_wvalue;
        logic                  ertn;
        csr_pkg::exc_cause_e   exc;
        logic [8:0]            esubcode;
    } mem_to_wb_t;

    // retired write that doubles as the register file write port
    typedef struct packed {
        logic [31:0] pc;
        logic        we;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } wb_trace_t;

    // flush request towards fetch
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

    typedef struct packed {
        logic        re;
        logic        we;
        logic [13:0] num;
        logic [31:0] wmask;
        logic [31:0] wvalue;
    } csr_cmd_t;

    typedef struct packed {
        logic        ex;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] pc;
        logic        ertn;
    } exc_cmd_t;

endpackage

/* logic/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic                clk,
    input  pipe_pkg::wb_trace_t trace,
    input  logic [4:0]          raddr,
    output logic [31:0]         rdata
);

    logic [31:0] regs [32];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (trace.we && trace.wnum != 5'd0) begin
            regs[trace.wnum] <= trace.wdata;
        end
    end

    // decode side read without bypass of the write in flight
    assign rdata = (raddr == 5'd0) ? 32'h0 : regs[raddr];

endmodule

/* logic/wb_stage.sv */
`timescale 1ns/100ps

module wb_stage (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  mem_valid,
    input  pipe_pkg::mem_to_wb_t  mem_bus,
    input  logic [31:0]           csr_rvalue,
    output logic                  wb_allowin,
    output pipe_pkg::wb_trace_t   trace,
    output pipe_pkg::csr_cmd_t    csr_cmd,
    output pipe_pkg::exc_cmd_t    exc_cmd
);

    logic                 wb_valid;
    pipe_pkg::mem_to_wb_t wb_bus;
    logic                 wb_ex;
    logic                 wb_ertn;
    logic                 flush;
    logic [5:0]           ecode;
    logic [31:0]          final_wdata;

    assign wb_allowin = 1'b1; // retire never stalls

    assign wb_ex   = wb_valid & (wb_bus.exc != csr_pkg::EXC_NONE);
    assign wb_ertn = wb_valid & wb_bus.ertn;
    assign flush   = wb_ex | wb_ertn;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (flush) begin
            wb_valid <= 1'b0; // drop whatever mem offers this cycle
        end else if (wb_allowin) begin
            wb_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid && wb_allowin) begin
            wb_bus <= mem_bus;
        end
    end

    // cause to estat ecode
    always_comb begin
        case (wb_bus.exc)
            csr_pkg::EXC_ADEF: ecode = csr_pkg::ECODE_ADEF;
            csr_pkg::EXC_ALE:  ecode = csr_pkg::ECODE_ALE;
            csr_pkg::EXC_SYS:  ecode = csr_pkg::ECODE_SYS;
            csr_pkg::EXC_BRK:  ecode = csr_pkg::ECODE_BRK;
            csr_pkg::EXC_INE:  ecode = csr_pkg::ECODE_INE;
            default:           ecode = 6'h00;
        endcase
    end

    // csr read data replaces the carried result
    assign final_wdata = wb_bus.csr_re ? csr_rvalue : wb_bus.rf_wdata;

    always_comb begin
        trace.pc    = wb_bus.pc;
        trace.we    = wb_bus.rf_we & wb_valid;
        trace.wnum  = wb_bus.rf_waddr;
        trace.wdata = final_wdata;
    end

    always_comb begin
        csr_cmd.re     = wb_bus.csr_re;
        csr_cmd.we     = wb_bus.csr_we & wb_valid & ~flush; // exception wins
        csr_cmd.num    = wb_bus.csr_num;
        csr_cmd.wmask  = wb_bus.csr_wmask;
        csr_cmd.wvalue = wb_bus.csr_wvalue;
    end

    always_comb begin
        exc_cmd.ex       = wb_ex;
        exc_cmd.ecode    = ecode;
        exc_cmd.esubcode = wb_bus.esubcode;
        exc_cmd.pc       = wb_bus.pc;
        exc_cmd.ertn     = wb_ertn;
    end

    // a retiring instruction either traps or returns, never both
    a_ex_ertn_excl: assert property (
        @(posedge clk) disable iff (!resetn)
        !(exc_cmd.ex && exc_cmd.ertn)
    );

endmodule

/* sim/commit_checker.sv */
`timescale 1ns/100ps

module commit_checker (
    input  logic                clk,
    input  logic                active,
    input  logic [7:0]          test_id,
    input  logic [3:0]          check_en,     // trace, redirect, rdata, last of test
    input  pipe_pkg::wb_trace_t exp_trace,
    input  pipe_pkg::redirect_t exp_redirect,
    input  logic [31:0]         exp_rdata,
    input  pipe_pkg::wb_trace_t trace,
    input  pipe_pkg::redirect_t redirect,
    input  logic [31:0]         rf_rdata,
    input  logic                wb_allowin,
    output int                  error_count,
    output int                  tests_passed,
    output int                  tests_failed
);

    int errors = 0;
    int test_errors = 0;
    int passed = 0;
    int failed = 0;

    assign error_count  = errors;
    assign tests_passed = passed;
    assign tests_failed = failed;

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'd1:    return "plain_writeback";
            8'd2:    return "invalid_bundle";
            8'd3:    return "csr_masked_write";
            8'd4:    return "exception_entry";
            8'd5:    return "ertn_return";
            8'd6:    return "exception_codes";
            default: return "unknown_test";
        endcase
    endfunction

    task automatic compare(input string field, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %h, actual %h",
                     test_name(test_id), field, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    // outputs settled since the falling edge, sampled ahead of the update
    always @(posedge clk) begin
        if (active) begin
            compare("wb_allowin", 32'd1, 32'(wb_allowin)); // no back-pressure
            if (check_en[3]) begin
                compare("trace.we", 32'(exp_trace.we), 32'(trace.we));
                if (exp_trace.we) begin
                    compare("trace.pc", exp_trace.pc, trace.pc);
                    compare("trace.wnum", 32'(exp_trace.wnum), 32'(trace.wnum));
                    compare("trace.wdata", exp_trace.wdata, trace.wdata);
                end
            end
            if (check_en[2]) begin
                compare("redirect.valid", 32'(exp_redirect.valid), 32'(redirect.valid));
                if (exp_redirect.valid) begin
                    compare("redirect.pc", exp_redirect.pc, redirect.pc);
                end
            end
            if (check_en[1]) begin
                compare("rf_rdata", exp_rdata, rf_rdata);
            end
            if (check_en[0]) begin
                if (test_errors == 0) begin
                    $display("test %s passed", test_name(test_id));
                    passed++;
                end else begin
                    $display("test %s failed, %0d errors", test_name(test_id), test_errors);
                    failed++;
                end
                test_errors = 0;
            end
        end
    end

endmodule

/* sim/commit_tb.sv */
`timescale 1ns/100ps

module commit_tb;

    localparam int WORDS   = 11; // hex words per vector line
    localparam int MAX_VEC = 64;

    logic                 clk;
    logic                 resetn;
    logic                 mem_valid;
    pipe_pkg::mem_to_wb_t mem_bus;
    logic [4:0]           rf_raddr;
    logic                 wb_allowin;
    pipe_pkg::wb_trace_t  trace;
    pipe_pkg::redirect_t  redirect;
    logic [31:0]          rf_rdata;

    logic                 active;
    logic [7:0]           test_id;
    logic [3:0]           check_en;
    pipe_pkg::wb_trace_t  exp_trace;
    pipe_pkg::redirect_t  exp_redirect;
    logic [31:0]          exp_rdata;
    int                   error_count;
    int                   tests_passed;
    int                   tests_failed;

    logic [31:0] vectors [WORDS*MAX_VEC];
    int          num_vec;
    int          cycles = 0;
    int          cycle_limit = 0;
    logic        data_bad;

    commit_top uut (
        .clk        (clk),
        .resetn     (resetn),
        .mem_valid  (mem_valid),
        .mem_bus    (mem_bus),
        .rf_raddr   (rf_raddr),
        .wb_allowin (wb_allowin),
        .trace      (trace),
        .redirect   (redirect),
        .rf_rdata   (rf_rdata)
    );

    commit_checker u_checker (
        .clk          (clk),
        .active       (active),
        .test_id      (test_id),
        .check_en     (check_en),
        .exp_trace    (exp_trace),
        .exp_redirect (exp_redirect),
        .exp_rdata    (exp_rdata),
        .trace        (trace),
        .redirect     (redirect),
        .rf_rdata     (rf_rdata),
        .wb_allowin   (wb_allowin),
        .error_count  (error_count),
        .tests_passed (tests_passed),
        .tests_failed (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // vectors end at a line whose test id is ff
    function automatic int count_vectors();
        int n;
        n = 0;
        while (n < MAX_VEC && vectors[n*WORDS][31:24] !== 8'hff) begin
            n++;
        end
        return n;
    endfunction

    task automatic apply_vector(input int idx);
        int          b;
        logic [31:0] ctl;
        logic [31:0] ectl;
        b    = idx * WORDS;
        ctl  = vectors[b];
        ectl = vectors[b+6];
        test_id            = ctl[31:24];
        mem_valid          = ctl[20];
        mem_bus.rf_we      = ctl[19];
        mem_bus.csr_re     = ctl[18];
        mem_bus.csr_we     = ctl[17];
        mem_bus.ertn       = ctl[16];
        mem_bus.exc        = csr_pkg::exc_cause_e'(ctl[14:12]);
        mem_bus.rf_waddr   = ctl[4:0];
        mem_bus.csr_num    = vectors[b+1][29:16];
        mem_bus.esubcode   = vectors[b+1][8:0];
        mem_bus.rf_wdata   = vectors[b+2];
        mem_bus.pc         = vectors[b+3];
        mem_bus.csr_wmask  = vectors[b+4];
        mem_bus.csr_wvalue = vectors[b+5];
        rf_raddr           = ectl[28:24];
        check_en           = ectl[23:20];
        exp_trace.we       = ectl[16];
        exp_trace.wnum     = ectl[4:0];
        exp_trace.pc       = vectors[b+7];
        exp_trace.wdata    = vectors[b+8];
        exp_redirect.valid = ectl[12];
        exp_redirect.pc    = vectors[b+9];
        exp_rdata          = vectors[b+10];
        active             = 1'b1;
    endtask

    initial begin
        resetn       = 1'b0;
        mem_valid    = 1'b0;
        mem_bus      = '0;
        rf_raddr     = 5'd0;
        active       = 1'b0;
        test_id      = 8'd0;
        check_en     = 4'd0;
        exp_trace    = '0;
        exp_redirect = '0;
        exp_rdata    = 32'd0;
        data_bad     = 1'b0;
        $readmemh("sim/commit_testdata.hex", vectors);
        num_vec = count_vectors();
        if (num_vec == MAX_VEC) begin
            $display("test data has no end marker, nothing was run");
            data_bad = 1'b1;
        end else begin
            cycle_limit = num_vec + 20;
            repeat (4) @(posedge clk);
            @(negedge clk);
            resetn = 1'b1;
            for (int i = 0; i < num_vec; i++) begin
                apply_vector(i);
                @(negedge clk);
            end
            active    = 1'b0;
            mem_valid = 1'b0;
            repeat (2) @(negedge clk);
        end
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && !data_bad) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        if (resetn) begin
            cycles = cycles + 1;
            if (cycle_limit > 0 && cycles > cycle_limit) begin
                $display("timeout, run still going after %0d cycles", cycle_limit);
                $display("SOME TESTS FAILED");
                $finish;
            end
        end
    end

endmodule

/* sim/commit_testdata.hex */
// ctl{id,valid,we/re/cwe/ertn,exc,waddr} csr{num,esub} rf_wdata pc wmask wvalue
// echk{raddr,chk,we,rvalid,wnum} exp_trace_pc exp_trace_wdata exp_redirect_pc exp_rdata
01180003 00000000 11112222 1c000000 00000000 00000000 00c00000 00000000 00000000 00000000 00000000
01180000 00000000 deadbeef 1c000004 00000000 00000000 00c10003 1c000000 11112222 00000000 00000000
01180007 00000000 000000a5 1c000008 00000000 00000000 03e10000 1c000004 deadbeef 00000000 11112222
01000000 00000000 00000000 00000000 00000000 00000000 00e10007 1c000008 000000a5 00000000 00000000
01000000 00000000 00000000 00000000 00000000 00000000 07f00000 00000000 00000000 00000000 000000a5
02080009 00000000 bad0bad0 1c000100 00000000 00000000 00c00000 00000000 00000000 00000000 00000000
02083009 00000000 bad1bad1 1c000104 00000000 00000000 00c00000 00000000 00000000 00000000 00000000
02000000 00000000 00000000 00000000 00000000 00000000 07f00000 00000000 00000000 00000000 000000a5
03120000 00300000 00000000 1c000200 ffffffff aaaaaaaa 00c00000 00000000 00000000 00000000 00000000
03120000 00300000 00000000 1c000204 0000ffff 12345678 00c00000 00000000 00000000 00000000 00000000
031c0005 00300000 00000000 1c000208 00000000 00000000 00c00000 00000000 00000000 00000000 00000000
03000000 00000000 00000000 00000000 00000000 00000000 00c10005 1c000208 aaaa5678 00000000 00000000
03000000 00000000 00000000 00000000 00000000 00000000 05f00000 00000000 00000000 00000000 aaaa5678
04120000 000c0000 00000000 1c000300 ffffffff 1c000100 00c00000 00000000 00000000 00000000 00000000
04120000 00000000 00000000 1c000304 00000004 00000004 00c00000 00000000 00000000 00000000 00000000
04103000 00000000 00000000 1c000308 00000000 00000000 00c00000 00000000 00000000 00000000 00000000
0418000a 00000000 55555555 1c00030c 00000000 00000000 00c01000 00000000 00000000 1c000100 00000000
041c0006 00060000 00000000 1c000400 00000000 00000000 00c00000 00000000 00000000 00000000 00000000
041c0006 00050000 00000000 1c000404 00000000 00000000 00c10006 1c000400 1c000308 00000000 00000000
041c0006 00000000 00000000 1c000408 00000000 00000000 00c10006 1c000404 000b0000 00000000 00000000
041c0006 00010000 00000000 1c00040c 00000000 00000000 00c10006 1c000408 00000008 00000000 00000000
04000000 00000000 00000000 00000000 00000000 00000000 06f10006 1c00040c 00000004 00000000 00000008
05110000 00000000 00000000 1c000500 00000000 00000000 00c00000 00000000 00000000 00000000 00000000
0518000b 00000000 66666666 1c000504 00000000 00000000 00c01000 00000000 00000000 1c000308 00000000
051c0008 00000000 00000000 1c000600 00000000 00000000 00c00000 00000000 00000000 00000000 00000000
05000000 00000000 00000000 00000000 00000000 00000000 00c10008 1c000600 0000000c 00000000 00000000
05000000 00000000 00000000 00000000 00000000 00000000 08f00000 00000000 00000000 00000000 0000000c
06101000 00000001 00000000 1c000700 00000000 00000000 00c00000 00000000 00000000 00000000 00000000
06000000 00000000 00000000 00000000 00000000 00000000 00c01000 00000000 00000000 1c000100 00000000
061c000c 00050000 00000000 1c000704 00000000 00000000 00c00000 00000000 00000000 00000000 00000000
06102000 00000000 00000000 1c000708 00000000 00000000 00c1000c 1c000704 00480000 00000000 00000000
06000000 00000000 00000000 00000000 00000000 00000000 00c01000 00000000 00000000 1c000100 00000000
061c000c 00050000 00000000 1c00070c 00000000 00000000 00c00000 00000000 00000000 00000000 00000000
06104000 00000000 00000000 1c000710 00000000 00000000 00c1000c 1c00070c 00090000 00000000 00000000
06000000 00000000 00000000 00000000 00000000 00000000 00c01000 00000000 00000000 1c000100 00000000
061c000c 00050000 00000000 1c000714 00000000 00000000 00c00000 00000000 00000000 00000000 00000000
06105000 00000000 00000000 1c000718 00000000 00000000 00c1000c 1c000714 000c0000 00000000 00000000
06000000 00000000 00000000 00000000 00000000 00000000 00c01000 00000000 00000000 1c000100 00000000
061c000c 00050000 00000000 1c00071c 00000000 00000000 00c00000 00000000 00000000 00000000 00000000
06000000 00000000 00000000 00000000 00000000 00000000 00c1000c 1c00071c 000d0000 00000000 00000000
06000000 00000000 00000000 00000000 00000000 00000000 0cf00000 00000000 00000000 00000000 000d0000
ff000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
